/* logic/decodePkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage shared types
// opcodes, alu ops, immediate kinds, control bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package decodePkg;

	// instruction bits 15:11
	typedef enum logic [4:0] {
		opHalt     = 5'b00000,
		opNop      = 5'b00001,
		opJ        = 5'b00100,
		opJr       = 5'b00101,
		opJal      = 5'b00110,
		opJalr     = 5'b00111,
		opAddi     = 5'b01000,
		opSubi     = 5'b01001,
		opXori     = 5'b01010,
		opAndni    = 5'b01011,
		opBeqz     = 5'b01100,
		opBnez     = 5'b01101,
		opBltz     = 5'b01110,
		opBgez     = 5'b01111,
		opSt       = 5'b10000,
		opLd       = 5'b10001,
		opSlbi     = 5'b10010,
		opLbi      = 5'b11000,
		// r-format groups, func bits 1:0 pick the op
		opAluShift = 5'b11010,
		opAluArith = 5'b11011,
		opSeq      = 5'b11100,
		opSlt      = 5'b11101,
		opSle      = 5'b11110,
		opSco      = 5'b11111
	} opcodeT;

	// consumed by execute
	typedef enum logic [3:0] {
		aluAdd   = 4'd0,
		aluSub   = 4'd1,
		aluXor   = 4'd2,
		aluAndn  = 4'd3,
		aluRol   = 4'd4,
		aluSll   = 4'd5,
		aluRor   = 4'd6,
		aluSrl   = 4'd7,
		aluSeq   = 4'd8,
		aluSlt   = 4'd9,
		aluSle   = 4'd10,
		aluSco   = 4'd11,
		aluPassB = 4'd12,
		// (a << 8) | b, for slbi
		aluSlbi  = 4'd13
	} aluOpT;

	typedef enum logic [2:0] {
		imm5Sext   = 3'd0,
		imm5Zext   = 3'd1,
		imm8Sext   = 3'd2,
		imm8Zext   = 3'd3,
		disp11Sext = 3'd4,
		immNone    = 3'd5
	} immKindT;

	typedef struct packed {
		logic  notHalt;
		logic  nop;
		logic  jal;
		logic  jr;
		logic  jump;
		logic  branch;
		logic  memToReg;
		logic  memRead;
		logic  memWrite;
		logic  aluSrc;
		logic  regWrite;
		aluOpT aluOp;
	} ctrlT;

	// nop opcode, rest of the word zero
	localparam logic [15:0] nopInstr = {opNop, 11'd0};

	// link register for jal and jalr
	localparam logic [2:0] linkReg = 3'd7;

endpackage

/* logic/regPortIf.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file read ports
// two selects out, two words back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface regPortIf;

	// port 1 is always rs
	logic [2:0]  read1Sel;
	logic [2:0]  read2Sel;
	logic [15:0] read1Data;
	logic [15:0] read2Data;

	// decoder side
	modport requester (
		output read1Sel, read2Sel,
		input  read1Data, read2Data
	);

	// register file side
	modport responder (
		input  read1Sel, read2Sel,
		output read1Data, read2Data
	);

endinterface

/* logic/controlUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control unit
// opcode to control bundle and immediate kind
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module controlUnit import decodePkg::*; (
	input  logic [15:0] instr,
	output ctrlT        ctrl,
	output immKindT     immKind
);

	opcodeT     opcode;
	logic [1:0] func;

	assign opcode = opcodeT'(instr[15:11]);
	// r-format function field
	assign func = instr[1:0];

	always_comb begin
		// running, nothing written
		ctrl = '0;
		ctrl.notHalt = 1'b1;
		ctrl.aluOp = aluAdd;
		immKind = immNone;

		case (opcode)
			opHalt: begin
				ctrl.notHalt = 1'b0;
			end
			opNop: begin
				ctrl.nop = 1'b1;
			end
			// i-format 1 alu ops
			opAddi, opSubi, opXori, opAndni: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				immKind = (opcode == opXori || opcode == opAndni) ? imm5Zext : imm5Sext;
				case (opcode)
					opSubi: ctrl.aluOp = aluSub;
					opXori: ctrl.aluOp = aluXor;
					opAndni: ctrl.aluOp = aluAndn;
					default: ctrl.aluOp = aluAdd;
				endcase
			end
			// address is rs + imm5
			opLd: begin
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				immKind = imm5Sext;
			end
			opSt: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				immKind = imm5Sext;
			end
			opBeqz, opBnez, opBltz, opBgez: begin
				ctrl.branch = 1'b1;
				immKind = imm8Sext;
			end
			opLbi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluPassB;
				immKind = imm8Sext;
			end
			opSlbi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluSlbi;
				immKind = imm8Zext;
			end
			// pc relative jumps
			opJ, opJal: begin
				ctrl.jump = 1'b1;
				ctrl.jal = (opcode == opJal);
				ctrl.regWrite = (opcode == opJal);
				immKind = disp11Sext;
			end
			// register jumps
			opJr, opJalr: begin
				ctrl.jump = 1'b1;
				ctrl.jr = 1'b1;
				ctrl.jal = (opcode == opJalr);
				ctrl.regWrite = (opcode == opJalr);
				immKind = imm8Sext;
			end
			opAluArith: begin
				ctrl.regWrite = 1'b1;
				case (func)
					2'b00: ctrl.aluOp = aluAdd;
					2'b01: ctrl.aluOp = aluSub;
					2'b10: ctrl.aluOp = aluXor;
					default: ctrl.aluOp = aluAndn;
				endcase
			end
			opAluShift: begin
				ctrl.regWrite = 1'b1;
				case (func)
					2'b00: ctrl.aluOp = aluRol;
					2'b01: ctrl.aluOp = aluSll;
					2'b10: ctrl.aluOp = aluRor;
					default: ctrl.aluOp = aluSrl;
				endcase
			end
			// set-on-compare group
			opSeq: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluSeq;
			end
			opSlt: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluSlt;
			end
			opSle: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluSle;
			end
			opSco: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluSco;
			end
			// unsupported opcodes behave as nop
			default: begin
				ctrl.nop = 1'b1;
			end
		endcase
	end

endmodule

/* logic/fieldDecode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction field decoder
// register selects, destination, extended immediate
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module fieldDecode import decodePkg::*; (
	input  logic [15:0]       instr,
	input  ctrlT              ctrl,
	input  immKindT           immKind,
	regPortIf.requester       rf,
	output logic [15:0]       immed,
	output logic [2:0]        writeSel
);

	logic [2:0] rs;
	logic [2:0] rt;
	logic [2:0] rd;
	logic       rFormat;

	// raw register fields
	assign rs = instr[10:8];
	assign rt = instr[7:5];
	assign rd = instr[4:2];

	// only r-format words carry no immediate
	assign rFormat = (immKind == immNone);

	// rs always on port 1
	assign rf.read1Sel = rs;

	// port 2 needed by r-format and by st (store data)
	// parked on r0 otherwise
	assign rf.read2Sel = (rFormat || ctrl.memWrite) ? rt : 3'd0;

	always_comb begin
		if (ctrl.jal) begin
			writeSel = linkReg;
		end else begin
			case (immKind)
				// i-format 1 writes bits 7:5
				imm5Sext, imm5Zext: writeSel = rt;
				// lbi and slbi write rs
				imm8Sext, imm8Zext: writeSel = rs;
				immNone: writeSel = rd;
				default: writeSel = rd;
			endcase
		end
	end

	always_comb begin
		case (immKind)
			imm5Sext: immed = {{11{instr[4]}}, instr[4:0]};
			imm5Zext: immed = {11'd0, instr[4:0]};
			imm8Sext: immed = {{8{instr[7]}}, instr[7:0]};
			imm8Zext: immed = {8'd0, instr[7:0]};
			// j and jal displacement
			disp11Sext: immed = {{5{instr[10]}}, instr[10:0]};
			default: immed = 16'd0;
		endcase
	end

endmodule

/* logic/regFileBypass.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file with write bypass
// 8 x 16, two async reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module regFileBypass (
	input  logic        clk,
	input  logic        reset,
	input  logic        wbEn,
	input  logic [2:0]  wbSel,
	input  logic [15:0] wbData,
	regPortIf.responder rf
);

	logic [15:0] regs [8];
	logic        hit1;
	logic        hit2;

	// writeback strobe, one word per clk
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= 16'd0;
			end
		end else if (wbEn) begin
			regs[wbSel] <= wbData;
		end
	end

	// same-cycle write seen by the read
	// r0 is stored but never bypassed
	assign hit1 = wbEn && (rf.read1Sel == wbSel) && (rf.read1Sel != 3'd0);
	assign hit2 = wbEn && (rf.read2Sel == wbSel) && (rf.read2Sel != 3'd0);

	assign rf.read1Data = hit1 ? wbData : regs[rf.read1Sel];
	assign rf.read2Data = hit2 ? wbData : regs[rf.read2Sel];

endmodule

/* logic/branchResolve.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch and jump resolution
// next pc and fetch flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module branchResolve import decodePkg::*; (
	input  ctrlT        ctrl,
	input  opcodeT      opcode,
	input  logic [15:0] immed,
	input  logic [15:0] rsData,
	input  logic [15:0] currPc,
	input  logic [15:0] incrPc,
	output logic [15:0] pcNext,
	output logic        flush
);

	logic [15:0] base;
	logic [15:0] target;
	logic        condMet;
	logic        taken;

	// jr and jalr are register relative, the rest pc relative
	assign base = ctrl.jr ? rsData : incrPc;
	assign target = base + immed;

	// condition on rs
	always_comb begin
		case (opcode)
			opBeqz: condMet = (rsData == 16'd0);
			opBnez: condMet = (rsData != 16'd0);
			// sign bit
			opBltz: condMet = rsData[15];
			opBgez: condMet = ~rsData[15];
			default: condMet = 1'b0;
		endcase
	end

	assign taken = ctrl.branch & condMet;

	always_comb begin
		if (!ctrl.notHalt) begin
			// halt holds the pc
			pcNext = currPc;
		end else if (taken || ctrl.jump) begin
			pcNext = target;
		end else begin
			pcNext = incrPc;
		end
	end

	// a redirect that lands on incrPc needs no flush
	assign flush = (ctrl.branch | ctrl.jump) && (pcNext != incrPc);

endmodule

/* logic/decodeStage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage top
// control, fields, register read, branch resolve
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module decodeStage import decodePkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        stall,
	input  logic [15:0] instr,
	input  logic [15:0] currPc,
	input  logic [15:0] incrPc,
	input  logic        wbEn,
	input  logic [2:0]  wbSel,
	input  logic [15:0] wbData,
	output logic        notHalt,
	output logic        nop,
	output logic        jal,
	output logic        jr,
	output logic        jump,
	output logic        branch,
	output logic        memToReg,
	output logic        memRead,
	output logic        memWrite,
	output logic        aluSrc,
	output logic        regWrite,
	output logic [3:0]  aluOp,
	output logic [2:0]  writeSel,
	output logic [15:0] immed,
	output logic [15:0] readData1,
	output logic [15:0] readData2,
	output logic [15:0] pcNext,
	output logic        flush
);

	logic [15:0] ctrlInstr;
	ctrlT        ctrl;
	ctrlT        fieldCtrl;
	immKindT     fieldImmKind;

	regPortIf rfPort ();

	// stall bubbles the control path only
	assign ctrlInstr = stall ? nopInstr : instr;

	// bundle seen by the outputs and the branch logic
	controlUnit ctrlUnit (
		.instr   (ctrlInstr),
		.ctrl    (ctrl),
		.immKind ()
	);

	// unstalled decode, fields keep following instr
	controlUnit fieldCtrlUnit (
		.instr   (instr),
		.ctrl    (fieldCtrl),
		.immKind (fieldImmKind)
	);

	fieldDecode fields (
		.instr    (instr),
		.ctrl     (fieldCtrl),
		.immKind  (fieldImmKind),
		.rf       (rfPort.requester),
		.immed    (immed),
		.writeSel (writeSel)
	);

	// written by writeback, not by this instruction
	regFileBypass regFile (
		.clk    (clk),
		.reset  (reset),
		.wbEn   (wbEn),
		.wbSel  (wbSel),
		.wbData (wbData),
		.rf     (rfPort.responder)
	);

	branchResolve branchUnit (
		.ctrl   (ctrl),
		.opcode (opcodeT'(instr[15:11])),
		.immed  (immed),
		.rsData (rfPort.read1Data),
		.currPc (currPc),
		.incrPc (incrPc),
		.pcNext (pcNext),
		.flush  (flush)
	);

	assign readData1 = rfPort.read1Data;
	assign readData2 = rfPort.read2Data;

	// flatten bundle
	assign notHalt  = ctrl.notHalt;
	assign nop      = ctrl.nop;
	assign jal      = ctrl.jal;
	assign jr       = ctrl.jr;
	assign jump     = ctrl.jump;
	assign branch   = ctrl.branch;
	assign memToReg = ctrl.memToReg;
	assign memRead  = ctrl.memRead;
	assign memWrite = ctrl.memWrite;
	assign aluSrc   = ctrl.aluSrc;
	assign regWrite = ctrl.regWrite;
	assign aluOp    = ctrl.aluOp;

endmodule

/* test/decodeStage_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage port checks
// stall, halt, flush and reset rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module decodeStage_asserts import decodePkg::*; (
	input logic        clk,
	input logic        reset,
	input logic        stall,
	input logic        wbEn,
	input logic [15:0] instr,
	input logic [15:0] currPc,
	input logic [15:0] incrPc,
	input logic        notHalt, nop, jal, jr, jump, branch,
	input logic        memToReg, memRead, memWrite, aluSrc, regWrite,
	input logic [15:0] readData1,
	input logic [15:0] readData2,
	input logic [15:0] pcNext,
	input logic        flush
);

	// bumped by every failing property, polled by the testbench
	int failCount = 0;

	// stall bubbles the control bundle
	stallBubble: assert property (@(posedge clk)
		stall |-> notHalt && nop && !regWrite && !memRead && !memWrite && !branch && !jump)
	else begin
		failCount++;
		$error("stall did not force a nop bundle");
	end

	// halt holds the pc, no redirect
	haltHold: assert property (@(posedge clk)
		!stall && instr[15:11] == 5'b00000 |-> pcNext == currPc && !flush)
	else begin
		failCount++;
		$error("halt did not hold the pc");
	end

	// flush only from an unstalled jump (001xx) or branch (011xx) word
	flushRule: assert property (@(posedge clk)
		flush |-> !stall && (instr[15:13] == 3'b001 || instr[15:13] == 3'b011)
			&& pcNext != incrPc)
	else begin
		failCount++;
		$error("flush without a redirect");
	end

	// nop during reset, only notHalt and nop set
	resetNop: assert property (@(posedge clk)
		reset && !stall && instr == nopInstr |-> notHalt && nop && !jal && !jr && !jump
			&& !branch && !memToReg && !memRead && !memWrite && !aluSrc && !regWrite && !flush)
	else begin
		failCount++;
		$error("control bundle not idle during reset");
	end

	// first cycle out of reset, all registers zero
	regsCleared: assert property (@(posedge clk)
		$past(reset) && !reset && !wbEn |-> readData1 == 16'd0 && readData2 == 16'd0)
	else begin
		failCount++;
		$error("register file not cleared by reset");
	end

endmodule

bind decodeStage decodeStage_asserts chk (.*);

/* test/decodeStageTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage testbench
// shadow registers, directed and random decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module decodeStageTb import decodePkg::*; ();

	logic        clk;
	logic        reset;
	logic        stall;
	logic [15:0] instr;
	logic [15:0] currPc;
	logic [15:0] incrPc;
	logic        wbEn;
	logic [2:0]  wbSel;
	logic [15:0] wbData;
	logic        notHalt, nop, jal, jr, jump, branch;
	logic        memToReg, memRead, memWrite, aluSrc, regWrite;
	logic [3:0]  aluOp;
	logic [2:0]  writeSel;
	logic [15:0] immed;
	logic [15:0] readData1;
	logic [15:0] readData2;
	logic [15:0] pcNext;
	logic        flush;

	// mirror of the register file
	logic [15:0] shadow [8];
	// write pending for the next edge
	logic        lastEn;
	logic [2:0]  lastSel;
	logic [15:0] lastData;

	opcodeT redirectOps [8] = '{opBeqz, opBnez, opBltz, opBgez, opJr, opJalr, opJ, opJal};
	opcodeT immOps [6] = '{opAddi, opSubi, opXori, opLbi, opSlbi, opJ};

	decodeStage dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stopWithFail();
		$display("Simulation finished: FAIL");
		$fatal(1, "decode stage test stopped");
	endtask

	// next rising edge, then the drive offset
	task automatic nextCycle();
		int waited;
		waited = 0;
		while (clk !== 1'b0 && waited < 60) begin
			#1;
			waited++;
		end
		while (clk !== 1'b1 && waited < 60) begin
			#1;
			waited++;
		end
		if (waited >= 60) begin
			$display("clock did not rise within 60 ns");
			stopWithFail();
		end
		#5;
	endtask

	task automatic checkWord(input string what, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			stopWithFail();
		end
	endtask

	// same-cycle write wins, except on r0
	function automatic logic [15:0] expRead(input logic [2:0] sel);
		if (wbEn && sel == wbSel && sel != 3'd0) begin
			return wbData;
		end
		return shadow[sel];
	endfunction

	function automatic logic [15:0] expImmed(input logic [15:0] ins);
		case (opcodeT'(ins[15:11]))
			opAddi, opSubi, opLd, opSt: return {{11{ins[4]}}, ins[4:0]};
			opXori, opAndni: return {11'd0, ins[4:0]};
			// branches and register jumps carry imm8
			opLbi, opBeqz, opBnez, opBltz, opBgez, opJr, opJalr: return {{8{ins[7]}}, ins[7:0]};
			opSlbi: return {8'd0, ins[7:0]};
			opJ, opJal: return {{5{ins[10]}}, ins[10:0]};
			default: return 16'd0;
		endcase
	endfunction

	// i-format 1 ops, lbi, slbi, and the arithmetic r-format group by func bits
	function automatic logic [3:0] expAluOp(input logic [15:0] ins);
		case (opcodeT'(ins[15:11]))
			opAddi: return aluAdd;
			opSubi: return aluSub;
			opXori: return aluXor;
			opAndni: return aluAndn;
			opLbi: return aluPassB;
			opSlbi: return aluSlbi;
			default: begin
				case (ins[1:0])
					2'b00: return aluAdd;
					2'b01: return aluSub;
					2'b10: return aluXor;
					default: return aluAndn;
				endcase
			end
		endcase
	endfunction

	function automatic logic [15:0] expPcNext(input logic [15:0] ins, input logic stl,
			input logic [15:0] rsVal);
		logic [15:0] target;
		target = incrPc + expImmed(ins);
		if (stl) begin
			return incrPc;
		end
		case (opcodeT'(ins[15:11]))
			opHalt: return currPc;
			opBeqz: return (rsVal == 16'd0) ? target : incrPc;
			opBnez: return (rsVal != 16'd0) ? target : incrPc;
			opBltz: return rsVal[15] ? target : incrPc;
			opBgez: return rsVal[15] ? incrPc : target;
			opJ, opJal: return target;
			opJr, opJalr: return rsVal + expImmed(ins);
			default: return incrPc;
		endcase
	endfunction

	// one drive per cycle, outputs checked 1 ns later
	task automatic step(input logic [15:0] ins, input logic stl, input logic en,
			input logic [2:0] sel, input logic [15:0] data);
		opcodeT      op;
		logic [15:0] pcExp;
		logic        redirect;
		nextCycle();
		// previous write has just been clocked in
		if (lastEn) begin
			shadow[lastSel] = lastData;
		end
		instr = ins;
		stall = stl;
		wbEn = en;
		wbSel = sel;
		wbData = data;
		currPc = 16'($urandom) & 16'hfffe;
		incrPc = currPc + 16'd2;
		lastEn = en;
		lastSel = sel;
		lastData = data;
		#1;
		op = opcodeT'(ins[15:11]);
		checkWord("readData1", readData1, expRead(ins[10:8]));
		// port 2 only defined for r-format and st
		if (op inside {opAluShift, opAluArith, opSeq, opSlt, opSle, opSco, opSt}) begin
			checkWord("readData2", readData2, expRead(ins[7:5]));
		end
		checkWord("immed", immed, expImmed(ins));
		pcExp = expPcNext(ins, stl, expRead(ins[10:8]));
		checkWord("pcNext", pcNext, pcExp);
		redirect = !stl && (op inside {opBeqz, opBnez, opBltz, opBgez, opJ, opJal, opJr, opJalr});
		checkWord("flush", {15'd0, flush}, {15'd0, redirect && (pcExp != incrPc)});
		if (op == opJal || op == opJalr) begin
			checkWord("writeSel", {13'd0, writeSel}, 16'd7);
		end
		// bubble or nop, only notHalt and nop high, alu left on add
		if (stl || ins == nopInstr) begin
			checkWord("control bits", {notHalt, nop, jal, jr, jump, branch, memToReg, memRead,
				memWrite, aluSrc, regWrite, aluOp, 1'b0}, 16'hc000);
		end
		if (!stl && op inside {opAddi, opSubi, opXori, opAndni, opLbi, opSlbi, opAluArith}) begin
			checkWord("aluOp", {12'd0, aluOp}, {12'd0, expAluOp(ins)});
		end
		if (dut.chk.failCount != 0) begin
			$display("a bound assertion on the DUT ports failed");
			stopWithFail();
		end
	endtask

	initial begin
		logic [2:0]  sel;
		logic [15:0] ins;
		void'($urandom(32'h6ce9_8068));
		reset = 1'b1;
		stall = 1'b0;
		instr = nopInstr;
		currPc = 16'd0;
		incrPc = 16'd2;
		wbEn = 1'b0;
		wbSel = 3'd0;
		wbData = 16'd0;
		lastEn = 1'b0;
		lastSel = 3'd0;
		lastData = 16'd0;
		for (int i = 0; i < 8; i++) begin
			shadow[i] = 16'd0;
		end
		for (int i = 0; i < 3; i++) begin
			nextCycle();
		end
		reset = 1'b0;

		// fresh out of reset, every register zero
		step(nopInstr, 1'b0, 1'b0, 3'd0, 16'd0);
		for (int r = 0; r < 8; r++) begin
			step({opAluArith, 3'(r), 3'(r), 5'd0}, 1'b0, 1'b0, 3'd0, 16'd0);
		end

		// random writebacks, every other read aimed at the written register
		for (int n = 0; n < 120; n++) begin
			sel = 3'($urandom);
			ins = 16'($urandom);
			if (n % 2 == 0) begin
				ins[10:8] = sel;
			end
			step(ins, ($urandom % 8) == 0, 1'($urandom), sel, 16'($urandom));
		end

		// r1 zero, r2 negative, r3 positive
		step(nopInstr, 1'b0, 1'b1, 3'd1, 16'd0);
		step(nopInstr, 1'b0, 1'b1, 3'd2, 16'h8004);
		step(nopInstr, 1'b0, 1'b1, 3'd3, 16'h0122);
		foreach (redirectOps[k]) begin
			for (int r = 1; r < 4; r++) begin
				step({redirectOps[k], 3'(r), 8'($urandom)}, 1'b0, 1'b0, 3'd0, 16'd0);
			end
		end

		// halt, with and without a stall
		step({opHalt, 11'($urandom)}, 1'b0, 1'b0, 3'd0, 16'd0);
		step({opHalt, 11'($urandom)}, 1'b1, 1'b0, 3'd0, 16'd0);

		// each immediate kind, sign bit both ways
		foreach (immOps[k]) begin
			for (int n = 0; n < 4; n++) begin
				ins = {immOps[k], 11'($urandom)};
				// top bit of imm5, imm8 and disp11 set on odd passes
				ins[4] = n[0];
				ins[7] = n[0];
				ins[10] = n[0];
				step(ins, 1'b0, 1'b0, 3'd0, 16'd0);
			end
		end

		nextCycle();
		if (dut.chk.failCount != 0) begin
			$display("a bound assertion on the DUT ports failed");
			stopWithFail();
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

/* wiscDecode.f */
logic/decodePkg.sv
logic/regPortIf.sv
logic/controlUnit.sv
logic/fieldDecode.sv
logic/regFileBypass.sv
logic/branchResolve.sv
logic/decodeStage.sv
test/decodeStage_asserts.sv
test/decodeStageTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f wiscDecode.f \
	--top-module decodeStageTb \
	-o decodeSim

# a bound assertion failure must not stop the run before the testbench reports it
./obj_dir/decodeSim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
else
	exit 1
fi
